//--- hdl/rv_opcode_pkg.sv
package rv_opcode_pkg;

    // ==================================================
    // Opcode field of the instruction word
    // ==================================================

    // Bits 1:0 are always 11 for 32-bit instructions, so only 6:2 are decoded
    localparam int opcode_lsb   = 2;
    localparam int opcode_width = 5;
    localparam int opcode_msb   = opcode_lsb + opcode_width - 1;

    // ==================================================
    // Major opcodes, instr[6:2]
    // ==================================================

    localparam logic [opcode_width-1:0] opc_load      = 5'b00000; // I-type
    localparam logic [opcode_width-1:0] opc_custom_ij = 5'b00010; // Custom "ij", I-type
    localparam logic [opcode_width-1:0] opc_op_imm    = 5'b00100; // Reg-imm ALU ops
    localparam logic [opcode_width-1:0] opc_auipc     = 5'b00101; // U-type
    localparam logic [opcode_width-1:0] opc_store     = 5'b01000; // S-type
    localparam logic [opcode_width-1:0] opc_op        = 5'b01100; // Reg-reg, imm is don't care
    localparam logic [opcode_width-1:0] opc_lui       = 5'b01101; // U-type
    localparam logic [opcode_width-1:0] opc_branch    = 5'b11000; // B-type
    localparam logic [opcode_width-1:0] opc_jalr      = 5'b11001; // I-type
    localparam logic [opcode_width-1:0] opc_jal       = 5'b11011; // J-type
    localparam logic [opcode_width-1:0] opc_system    = 5'b11100; // CSR access, I-type

    // ==================================================
    // Immediate format codes
    // ==================================================

    // Codes 011 and 110 are never produced by the decoder
    localparam int imm_kind_width = 3;

    localparam logic [imm_kind_width-1:0] kind_u    = 3'b000;
    localparam logic [imm_kind_width-1:0] kind_j    = 3'b001;
    localparam logic [imm_kind_width-1:0] kind_b    = 3'b010;
    localparam logic [imm_kind_width-1:0] kind_s    = 3'b100;
    localparam logic [imm_kind_width-1:0] kind_i    = 3'b101;
    localparam logic [imm_kind_width-1:0] kind_pass = 3'b111; // No expansion, ALU result

endpackage

//--- hdl/imm_format_pkg.sv
package imm_format_pkg;

    localparam int instr_width = 32;

    // ==================================================
    // Per-format views of one instruction word
    // ==================================================

    // All views list fields from bit 31 down to bit 0

    typedef struct packed {
        logic       sign;     // imm[11], also the sign
        logic [5:0] imm_10_5;
        logic [4:0] imm_4_0;  // Bits 24:20
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_i_t;

    typedef struct packed {
        logic       sign;     // imm[11]
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;  // Sits where rd would be
        logic [6:0] opcode;
    } instr_s_t;

    typedef struct packed {
        logic       sign;     // imm[12]
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;   // Bit 7, the odd one out
        logic [6:0] opcode;
    } instr_b_t;

    typedef struct packed {
        logic        sign;      // imm[31]
        logic [18:0] imm_30_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_u_t;

    typedef struct packed {
        logic       sign;      // imm[20]
        logic [9:0] imm_10_1;
        logic       imm_11;    // Bit 20
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_j_t;

    // Same 32 bits, read according to the decoded format
    typedef union packed {
        logic [instr_width-1:0] raw;
        instr_i_t               i;
        instr_s_t               s;
        instr_b_t               b;
        instr_u_t               u;
        instr_j_t               j;
    } instr_word_t;

endpackage

//--- hdl/imm_kind_decoder.sv
module imm_kind_decoder import rv_opcode_pkg::*; (
    input  logic                      imm_expand, // Decode cycle, expand the immediate
    input  logic [opcode_width-1:0]   opcode,     // instr[6:2]
    output logic [imm_kind_width-1:0] imm_kind    // Format code to the expander
);

    // ==================================================
    // Opcode to format table
    // ==================================================

    //  opcode  format
    //  00000   I   load
    //  00010   I   custom ij
    //  00100   I   op-imm
    //  00101   U   auipc
    //  01000   S   store
    //  01100   I   op, result unused
    //  01101   U   lui
    //  11000   B   branch
    //  11001   I   jalr
    //  11011   J   jal
    //  11100   I   system
    //  others  U

    always_comb begin
        if (!imm_expand) begin
            imm_kind = kind_pass; // Not a decode cycle
        end else begin
            case (opcode)
                opc_load:      imm_kind = kind_i;
                opc_op_imm:    imm_kind = kind_i;
                opc_jalr:      imm_kind = kind_i;
                opc_op:        imm_kind = kind_i;
                opc_system:    imm_kind = kind_i;
                opc_custom_ij: imm_kind = kind_i;  // Custom op shares I layout
                opc_auipc:     imm_kind = kind_u;
                opc_lui:       imm_kind = kind_u;
                opc_store:     imm_kind = kind_s;
                opc_branch:    imm_kind = kind_b;
                opc_jal:       imm_kind = kind_j;
                default:       imm_kind = kind_u;  // Illegal opcodes, cheapest pattern
            endcase
        end
    end

endmodule

//--- hdl/imm_expander.sv
module imm_expander import rv_opcode_pkg::*, imm_format_pkg::*; #(
    parameter int alu_width = 32
) (
    input  instr_word_t               instr,    // Instruction being decoded
    input  logic [alu_width-1:0]      b,        // ALU result
    input  logic [imm_kind_width-1:0] imm_kind, // From the decoder
    output logic [alu_width-1:0]      operand   // To the working register
);

    // ==================================================
    // Immediates for each format
    // ==================================================

    logic [instr_width-1:0] imm_u;
    logic [instr_width-1:0] imm_j;
    logic [instr_width-1:0] imm_b;
    logic [instr_width-1:0] imm_s;
    logic [instr_width-1:0] imm_i;
    logic [instr_width-1:0] imm_sel; // Chosen immediate, full width

    // U: upper 20 bits in place, low 12 cleared
    assign imm_u = {instr.u.sign, instr.u.imm_30_12, 12'b0};

    // J: 21-bit offset, halfword aligned
    assign imm_j = {{12{instr.j.sign}},
                    instr.j.imm_19_12,
                    instr.j.imm_11,
                    instr.j.imm_10_1,
                    1'b0};

    // B: 13-bit offset, bit 11 comes from instr[7]
    assign imm_b = {{20{instr.b.sign}},
                    instr.b.imm_11,
                    instr.b.imm_10_5,
                    instr.b.imm_4_1,
                    1'b0};

    assign imm_s = {{21{instr.s.sign}}, instr.s.imm_10_5, instr.s.imm_4_0}; // Store offset
    assign imm_i = {{21{instr.i.sign}}, instr.i.imm_10_5, instr.i.imm_4_0}; // 12-bit signed

    // ==================================================
    // Format select
    // ==================================================

    always_comb begin
        imm_sel = imm_i;
        case (imm_kind)
            kind_u:  imm_sel = imm_u;
            kind_j:  imm_sel = imm_j;
            kind_b:  imm_sel = imm_b;
            kind_s:  imm_sel = imm_s;
            default: imm_sel = imm_i; // kind_i
        endcase
    end

    // Pass code bypasses the immediate entirely
    always_comb begin
        if (imm_kind == kind_pass) begin
            operand = b;
        end else begin
            operand = imm_sel[alu_width-1:0]; // Truncated for narrow ALUs
        end
    end

endmodule

//--- hdl/adr_register.sv
module adr_register #(
    parameter int alu_width = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ena_q,        // Update strobe
    input  logic                 keep_q,       // Low clears on the next enabled edge
    input  logic                 core_running, // Held clear while the core is stopped
    input  logic [alu_width-1:0] operand,      // Immediate or ALU result
    input  logic [alu_width-1:0] b,            // ALU result, for zero detect
    output logic [alu_width-1:0] adr,          // Working register, also I/O address
    output logic                 alu_nonzero   // Low when b was all zeros
);

    // ==================================================
    // Zero detect and clear condition
    // ==================================================

    logic b_nonzero;
    logic clr;

    assign b_nonzero = (b != '0);

    // Either source clears the register
    assign clr = !keep_q || !core_running;

    // ==================================================
    // Register
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adr         <= '0;
            alu_nonzero <= 1'b0;
        end else if (ena_q) begin
            if (clr) begin
                adr         <= '0;   // Synchronous clear
                alu_nonzero <= 1'b0;
            end else begin
                adr         <= operand;
                alu_nonzero <= b_nonzero;
            end
        end
        // ena_q low holds both
    end

    // ==================================================
    // Checks
    // ==================================================

    // A clear must reach both outputs on the following cycle
    a_clear : assert property (
        @(posedge clk) disable iff (!rst_n)
        (ena_q && clr) |=> (adr == '0 && !alu_nonzero)
    ) else $error("adr_register: clear missed, adr=%h nz=%b", adr, alu_nonzero);

    // Hold when not enabled
    a_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        !ena_q |=> ($stable(adr) && $stable(alu_nonzero))
    ) else $error("adr_register: outputs moved without ena_q");

endmodule

//--- hdl/immexp_zfind_top.sv
module immexp_zfind_top import rv_opcode_pkg::*, imm_format_pkg::*; #(
    parameter int alu_width = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [alu_width-1:0]   b,            // ALU output
    input  logic [instr_width-1:0] instr,        // Current instruction
    input  logic                   imm_expand,   // Expand immediate this cycle
    input  logic                   keep_q,       // Low clears adr, with ena_q
    input  logic                   core_running, // Not running keeps adr clear
    input  logic                   ena_q,        // Update adr
    output logic [alu_width-1:0]   adr,          // Working register, I/O address
    output logic                   alu_nonzero   // Registered b != 0
);

    // ==================================================
    // Internal nets
    // ==================================================

    logic [imm_kind_width-1:0] imm_kind;
    logic [alu_width-1:0]      operand;

    // ==================================================
    // Datapath
    // ==================================================

    imm_kind_decoder u_decoder (
        .imm_expand (imm_expand),
        .opcode     (instr[opcode_msb:opcode_lsb]), // Bits 1:0 ignored
        .imm_kind   (imm_kind)
    );

    imm_expander #(
        .alu_width (alu_width)
    ) u_expander (
        .instr    (instr),
        .b        (b),
        .imm_kind (imm_kind),
        .operand  (operand)
    );

    adr_register #(
        .alu_width (alu_width)
    ) u_adr_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .ena_q        (ena_q),
        .keep_q       (keep_q),
        .core_running (core_running),
        .operand      (operand),
        .b            (b),          // Zero detect on the raw ALU result
        .adr          (adr),
        .alu_nonzero  (alu_nonzero)
    );

endmodule

//--- bench/tb_imm_model.svh
`ifndef TB_IMM_MODEL_SVH
`define TB_IMM_MODEL_SVH

// ==================================================
// Immediate formats of the RISC-V base ISA
// ==================================================

// 12-bit signed, bits 31:20
function automatic logic [31:0] sext_i(input logic [31:0] w);
    return {{20{w[31]}}, w[31:20]};
endfunction

// Store offset split over 31:25 and 11:7
function automatic logic [31:0] store_offset(input logic [31:0] w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
endfunction

// Branch offset, bit 11 taken from w[7], halfword aligned
function automatic logic [31:0] branch_offset(input logic [31:0] w);
    return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic logic [31:0] upper_imm(input logic [31:0] w);
    return {w[31:12], 12'b0}; // Low 12 cleared
endfunction

// Jump offset, 21 bits
function automatic logic [31:0] jump_offset(input logic [31:0] w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
endfunction

// Format chosen by bits 6:2, unknown opcodes read as U
function automatic logic [31:0] expected_imm(input logic [31:0] w);
    logic [31:0] imm;
    case (w[6:2])
        5'b00000, 5'b00010, 5'b00100,
        5'b01100, 5'b11001, 5'b11100: imm = sext_i(w);      // load, ij, op-imm, op, jalr, system
        5'b00101, 5'b01101:           imm = upper_imm(w);   // auipc, lui
        5'b01000:                     imm = store_offset(w);
        5'b11000:                     imm = branch_offset(w);
        5'b11011:                     imm = jump_offset(w);
        default:                      imm = upper_imm(w);
    endcase
    return imm;
endfunction

`endif

//--- bench/tb_immexp_zfind.sv
module tb_immexp_zfind;

    localparam int alu_width    = 32;
    localparam int flag_timeout = 8; // Cycles allowed for the flag to settle

    logic                 clk = 1'b0; // Low from time zero, no edge at start
    logic                 rst_n;
    logic [alu_width-1:0] b;
    logic [31:0]          instr;
    logic                 imm_expand;
    logic                 keep_q;
    logic                 core_running;
    logic                 ena_q;
    logic [alu_width-1:0] adr;
    logic                 alu_nonzero;

    logic [alu_width-1:0] exp_adr; // Reference register
    logic                 exp_nz;

    // All eleven recognized opcodes, then a few that are not
    logic [4:0] listed_opcodes [11] = '{5'b00000, 5'b00010, 5'b00100, 5'b00101,
                                        5'b01000, 5'b01100, 5'b01101, 5'b11000,
                                        5'b11001, 5'b11011, 5'b11100};
    logic [4:0] unlisted_opcodes [6] = '{5'b00001, 5'b00011, 5'b00110,
                                         5'b10100, 5'b11010, 5'b11111};

    `include "tb_imm_model.svh"

    // ==================================================
    // DUT and clock
    // ==================================================

    immexp_zfind_top #(
        .alu_width (alu_width)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .b            (b),
        .instr        (instr),
        .imm_expand   (imm_expand),
        .keep_q       (keep_q),
        .core_running (core_running),
        .ena_q        (ena_q),
        .adr          (adr),
        .alu_nonzero  (alu_nonzero)
    );

    always #10 clk = ~clk;

    // Expected outputs from the update rules
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_adr <= '0;
            exp_nz  <= 1'b0;
        end else if (ena_q) begin
            if (!keep_q || !core_running) begin
                exp_adr <= '0;
                exp_nz  <= 1'b0;
            end else begin
                exp_adr <= imm_expand ? expected_imm(instr) : b;
                exp_nz  <= (b != '0);
            end
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    task automatic report_mismatch(input string sig, input logic [alu_width-1:0] expected,
                                   input logic [alu_width-1:0] actual);
        $display("[ERROR] time %0t: %s expected %h, actual %h", $time, sig, expected, actual);
        $display("Test failed");
        $fatal(1, "%s mismatch", sig);
    endtask

    task automatic report_failure(input string what);
        $display("%s, at time %0t", what, $time);
        $display("Test failed");
        $fatal(1, "%s", what);
    endtask

    // Outputs are stable at the falling edge
    a_adr_match : assert property (@(negedge clk) adr == exp_adr)
        else report_mismatch("adr", exp_adr, adr);

    a_nz_match : assert property (@(negedge clk) alu_nonzero == exp_nz)
        else report_mismatch("alu_nonzero", {{(alu_width-1){1'b0}}, exp_nz},
                             {{(alu_width-1){1'b0}}, alu_nonzero});

    a_clear_seen : assert property (@(posedge clk) disable iff (!rst_n)
        (ena_q && (!keep_q || !core_running)) |=> (adr == '0 && !alu_nonzero))
        else report_failure("Outputs not cleared after an enabled clear");

    a_hold_seen : assert property (@(posedge clk) disable iff (!rst_n)
        !ena_q |=> ($stable(adr) && $stable(alu_nonzero)))
        else report_failure("Outputs changed while ena_q was low");

    // ==================================================
    // Stimulus helpers
    // ==================================================

    task automatic drive(input logic [alu_width-1:0] b_val, input logic [31:0] instr_val,
                         input logic expand, input logic keep, input logic run,
                         input logic ena);
        @(negedge clk);
        b            = b_val;
        instr        = instr_val;
        imm_expand   = expand;
        keep_q       = keep;
        core_running = run;
        ena_q        = ena;
    endtask

    // Polls alu_nonzero at falling edges
    task automatic await_flag(input logic want, input int limit);
        int waited;
        waited = 0;
        while (alu_nonzero !== want && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (alu_nonzero !== want) begin
            report_failure($sformatf("Timed out waiting for alu_nonzero = %0b", want));
        end
    endtask

    function automatic logic [alu_width-1:0] random_alu_value();
        if ($urandom_range(0, 3) == 0) begin
            return '0; // Zero one time in four
        end
        return alu_width'($urandom);
    endfunction

    function automatic logic [31:0] random_word(input logic [4:0] opc);
        logic [31:0] w;
        w      = $urandom;
        w[6:2] = opc;
        w[1:0] = 2'b11; // 32-bit encoding
        return w;
    endfunction

    // ==================================================
    // Sequence
    // ==================================================

    initial begin
        int i;
        int j;
        int sel;
        rst_n        = 1'b0;
        b            = '0;
        instr        = '0;
        imm_expand   = 1'b0;
        keep_q       = 1'b0;
        core_running = 1'b0;
        ena_q        = 1'b0;
        void'($urandom(32'h49bba3f2));

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // No enable yet, outputs stay zero
        for (i = 0; i < 3; i++) drive(random_alu_value(), $urandom, 1'b0, 1'b1, 1'b1, 1'b0);

        // Pass-through of b
        for (i = 0; i < 40; i++) drive(random_alu_value(), $urandom, 1'b0, 1'b1, 1'b1, 1'b1);
        drive(alu_width'(1), $urandom, 1'b0, 1'b1, 1'b1, 1'b1);
        await_flag(1'b1, flag_timeout);

        // Every listed opcode
        for (i = 0; i < 11; i++) begin
            for (j = 0; j < 8; j++) begin
                drive(random_alu_value(), random_word(listed_opcodes[i]), 1'b1, 1'b1, 1'b1, 1'b1);
            end
        end

        // Unlisted opcodes fall back to U
        for (i = 0; i < 24; i++) begin
            sel = $urandom_range(0, 5);
            drive(random_alu_value(), random_word(unlisted_opcodes[sel]), 1'b1, 1'b1, 1'b1, 1'b1);
        end

        // Clear by keep_q, core_running or both
        for (i = 0; i < 30; i++) begin
            sel = $urandom_range(0, 2);
            drive(random_alu_value(), $urandom, 1'($urandom), sel == 1, sel == 0, 1'b1);
        end
        await_flag(1'b0, flag_timeout);

        // Load something, then hold it under noise
        drive(alu_width'(32'hdead_beef), $urandom, 1'b0, 1'b1, 1'b1, 1'b1);
        for (i = 0; i < 30; i++) begin
            drive(random_alu_value(), $urandom, 1'($urandom), 1'($urandom), 1'($urandom), 1'b0);
        end

        // Mixed traffic, clears rarer than updates
        for (i = 0; i < 60; i++) begin
            drive(random_alu_value(), random_word(listed_opcodes[$urandom_range(0, 10)]),
                  1'($urandom), $urandom_range(0, 7) != 0, $urandom_range(0, 7) != 0,
                  1'($urandom));
        end

        drive('0, '0, 1'b0, 1'b1, 1'b1, 1'b0);
        repeat (2) @(negedge clk); // Last update gets checked

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- sim.f
+incdir+bench
hdl/rv_opcode_pkg.sv
hdl/imm_format_pkg.sv
hdl/imm_kind_decoder.sv
hdl/imm_expander.sv
hdl/adr_register.sv
hdl/immexp_zfind_top.sv
bench/tb_immexp_zfind.sv

//--- Makefile
# Verilator flow for the immediate expander and zero finder

VERILATOR  ?= verilator
TOP        := tb_immexp_zfind
FILELIST   := sim.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Test failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi; \
	echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
